/* verification/memCtrlCases.txt */
// op addr len wdata expected, all hex; op 0 fetch, 1 load, 2 store, 3 end
// a store expects 1 as its done marker; fetch len is always 4
1 00100 2 00000000 00000000
2 00010 1 000000a5 00000001
1 00010 1 00000000 000000a5
2 00020 2 0000c3d2 00000001
1 00020 2 00000000 0000c3d2
2 00030 4 89abcdef 00000001
1 00030 4 00000000 89abcdef
1 00030 1 00000000 000000ef
1 00031 2 00000000 0000abcd
0 00030 4 00000000 89abcdef
2 00050 1 00000011 00000001
2 00051 1 00000022 00000001
2 00052 2 00004433 00000001
0 00050 4 00000000 44332211
0 00200 4 00000000 00000000
1 00300 4 00000000 00000000
2 00060 4 deadbeef 00000001
0 00060 4 00000000 deadbeef
2 00061 1 00000000 00000001
0 00060 4 00000000 dead00ef
1 00062 2 00000000 0000dead
2 1fffc 4 01020304 00000001
1 1fffe 2 00000000 00000102
1 00010 4 00000000 000000a5
3 00000 0 00000000 00000000

/* memCtrl.f */
hw/memPkg.sv
hw/byteRam.sv
hw/memRequestDecode.sv
hw/memByteSequencer.sv
hw/memResultAssemble.sv
hw/memCtrlTop.sv
verification/memCtrlTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= memCtrlTb
FILELIST  ?= memCtrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/memCtrlTb.sv */
`default_nettype none

module memCtrlTb
    import memPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ADDR_W    = 17;
    localparam int COLS      = 5;
    localparam int MAX_CASES = 64;

    logic              clk = 1'b0;
    logic              rst;
    logic              stall;
    logic              fetchValid;
    logic [ADDR_W-1:0] fetchAddr;
    logic              fetchReady;
    logic              dataValid;
    memReqT            dataReq;
    logic              dataReady;
    logic              fetchRspValid;
    fetchRspT          fetchRsp;
    logic              fetchRspReady;
    logic              dataRspValid;
    dataRspT           dataRsp;
    logic              dataRspReady;

    // columns: op, addr, len, wdata, expected
    logic [31:0] caseMem [COLS*MAX_CASES];
    logic [31:0] lfsr;
    int          acceptCycle [MAX_CASES];
    int          pending [$];
    int          fetchCase;
    int          dataCase;
    int          doneCount;
    int          mismatches;
    int          otherErrors;

    memCtrlTop #(.ADDR_W(ADDR_W)) u_dut (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .fetchValid    (fetchValid),
        .fetchAddr     (fetchAddr),
        .fetchReady    (fetchReady),
        .dataValid     (dataValid),
        .dataReq       (dataReq),
        .dataReady     (dataReady),
        .fetchRspValid (fetchRspValid),
        .fetchRsp      (fetchRsp),
        .fetchRspReady (fetchRspReady),
        .dataRspValid  (dataRspValid),
        .dataRsp       (dataRsp),
        .dataRspReady  (dataRspReady)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] caseWord(input int i, input int col);
        return caseMem[i*COLS+col];
    endfunction

    function automatic memOpE caseOp(input int i);
        logic [31:0] w;
        w = caseMem[i*COLS];
        return memOpE'(w[1:0]);
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBit(output logic b);
        lfsr = lfsrStep(lfsr);
        b    = lfsr[0];
    endtask

    // stall about one cycle in eight, each ready low about one in four
    task automatic drawNoise();
        logic b0, b1, b2;
        takeBit(b0);
        takeBit(b1);
        takeBit(b2);
        stall = b0 & b1 & b2;
        takeBit(b0);
        takeBit(b1);
        fetchRspReady = b0 | b1;
        takeBit(b0);
        takeBit(b1);
        dataRspReady = b0 | b1;
    endtask

    task automatic presentCase(input int i);
        logic [31:0] addr;
        logic [31:0] len;
        addr = caseWord(i, 1);
        len  = caseWord(i, 2);
        if (caseOp(i) == opFetch) begin
            fetchValid = 1'b1;
            fetchAddr  = addr[ADDR_W-1:0];
            fetchCase  = i;
        end else begin
            dataValid = 1'b1;
            dataReq   = '{op: caseOp(i), addr: addr, len: len[2:0], wdata: caseWord(i, 3)};
            dataCase  = i;
        end
    endtask

    task automatic checkFetch(input fetchRspT got, input fetchRspT exp, input int caseNum);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: case %0d fetch inst %h, expected %h",
                     $time, caseNum, got.inst, exp.inst);
        end
    endtask

    // a store only signals completion, rdata carries nothing
    task automatic checkData(input dataRspT got, input dataRspT exp, input int caseNum);
        if (got.isStore !== exp.isStore || (!exp.isStore && got.rdata !== exp.rdata)) begin
            mismatches++;
            $display("Mismatch at %0t: case %0d data rdata %h isStore %b, expected %h isStore %b",
                     $time, caseNum, got.rdata, got.isStore, exp.rdata, exp.isStore);
        end
    endtask

    task automatic checkLatency(input int got, input int exp, input int caseNum);
        if (got != exp) begin
            mismatches++;
            $display("Mismatch at %0t: case %0d latency %0d cycles, expected %0d",
                     $time, caseNum, got, exp);
        end
    endtask

    task automatic takeResponse(input logic isFetch, input int cycle);
        int       idx;
        fetchRspT expF;
        dataRspT  expD;
        if (pending.size() == 0) begin
            otherErrors++;
            $display("Error at %0t: a response arrived with no request outstanding", $time);
        end else begin
            idx  = pending.pop_front();
            expF = '{inst: caseWord(idx, 4)};
            expD = '{rdata: caseWord(idx, 4), isStore: caseOp(idx) == opStore};
            if (isFetch != (caseOp(idx) == opFetch)) begin
                otherErrors++;
                $display("Error at %0t: case %0d was answered on the wrong port", $time, idx);
            end else if (isFetch) begin
                checkFetch(fetchRsp, expF, idx);
            end else begin
                checkData(dataRsp, expD, idx);
            end
            // first case runs alone on a quiet, idle controller
            if (idx == 0) begin
                checkLatency(cycle - acceptCycle[0], int'(caseWord(0, 2)) + 3, 0);
            end
            doneCount++;
        end
    endtask

    initial begin
        int   i;
        int   limit;
        int   cycle;
        int   numCases;
        int   nextCase;
        logic dataXfer;
        logic fetchXfer;
        logic fetchRspXfer;
        logic dataRspXfer;

        rst           = 1'b1;
        stall         = 1'b0;
        fetchValid    = 1'b0;
        fetchAddr     = '0;
        dataValid     = 1'b0;
        dataReq       = '0;
        fetchRspReady = 1'b1;
        dataRspReady  = 1'b1;
        lfsr          = 32'ha601_ba93;
        fetchCase     = 0;
        dataCase      = 0;
        doneCount     = 0;
        mismatches    = 0;
        otherErrors   = 0;
        cycle         = 0;
        nextCase      = 0;

        // op 3 marks the end of the list
        for (i = 0; i < COLS*MAX_CASES; i++) begin
            caseMem[i] = 32'h3;
        end
        $readmemh("verification/memCtrlCases.txt", caseMem);
        numCases = 0;
        while (numCases < MAX_CASES && caseMem[numCases*COLS] != 32'h3) begin
            numCases++;
        end
        limit = numCases * 20 + 100;
        if (numCases == 0) begin
            otherErrors++;
            $display("Error: no cases were read from the case file");
        end

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        while (doneCount < numCases && cycle < limit) begin
            @(negedge clk);
            cycle++;
            dataXfer     = dataValid && dataReady && !stall;
            fetchXfer    = fetchValid && fetchReady && !stall;
            fetchRspXfer = fetchRspValid && fetchRspReady && !stall;
            dataRspXfer  = dataRspValid && dataRspReady && !stall;

            if (fetchRspXfer) begin
                takeResponse(1'b1, cycle);
            end
            if (dataRspXfer) begin
                takeResponse(1'b0, cycle);
            end
            if (fetchXfer && dataValid) begin
                otherErrors++;
                $display("Error at %0t: fetch was accepted ahead of a waiting data request",
                         $time);
            end
            if (dataXfer) begin
                pending.push_back(dataCase);
                acceptCycle[dataCase] = cycle;
            end
            if (fetchXfer) begin
                pending.push_back(fetchCase);
                acceptCycle[fetchCase] = cycle;
            end

            @(posedge clk);
            #1;
            if (dataXfer) begin
                dataValid = 1'b0;
            end
            if (fetchXfer) begin
                fetchValid = 1'b0;
            end
            if (!dataValid && !fetchValid && nextCase < numCases
                    && (nextCase == 0 || doneCount > 0)) begin
                presentCase(nextCase);
                nextCase++;
                // fetch after a load or store goes out in the same cycle
                if (caseOp(nextCase - 1) != opFetch && nextCase < numCases
                        && caseOp(nextCase) == opFetch) begin
                    presentCase(nextCase);
                    nextCase++;
                end
            end
            if (doneCount > 0) begin
                drawNoise();
            end
        end

        if (doneCount < numCases) begin
            otherErrors++;
            $display("Timeout after %0d cycles: %0d of %0d responses received",
                     cycle, doneCount, numCases);
        end else begin
            repeat (10) begin
                @(negedge clk);
                if (fetchRspValid || dataRspValid) begin
                    otherErrors++;
                    $display("Error at %0t: extra response after all cases completed", $time);
                end
            end
        end

        $display("Summary: %0d mismatches, %0d other errors, %0d of %0d cases answered",
                 mismatches, otherErrors, doneCount, numCases);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/memCtrlTop.sv */
`default_nettype none

module memCtrlTop
    import memPkg::*;
#(
    parameter int ADDR_W = 17
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,

    input  logic              fetchValid,
    input  logic [ADDR_W-1:0] fetchAddr,
    output logic              fetchReady,

    input  logic              dataValid,
    input  memReqT            dataReq,
    output logic              dataReady,

    output logic              fetchRspValid,
    output fetchRspT          fetchRsp,
    input  logic              fetchRspReady,

    output logic              dataRspValid,
    output dataRspT           dataRsp,
    input  logic              dataRspReady
);

    logic              reqValid;
    memReqT            req;
    logic              reqReady;
    logic              busyResult;
    logic [ADDR_W-1:0] ramAddr;
    logic              ramWe;
    logic [BYTE_W-1:0] ramWdata;
    logic [BYTE_W-1:0] ramRdata;
    logic              beatValid;
    memBeatT           beat;

    memRequestDecode #(.ADDR_W(ADDR_W)) uDecode (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .fetchValid (fetchValid),
        .fetchAddr  (fetchAddr),
        .fetchReady (fetchReady),
        .dataValid  (dataValid),
        .dataReq    (dataReq),
        .dataReady  (dataReady),
        .reqValid   (reqValid),
        .req        (req),
        .reqReady   (reqReady)
    );

    memByteSequencer #(.ADDR_W(ADDR_W)) uSequencer (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .reqValid   (reqValid),
        .req        (req),
        .reqReady   (reqReady),
        .busyResult (busyResult),
        .ramAddr    (ramAddr),
        .ramWe      (ramWe),
        .ramWdata   (ramWdata),
        .beatValid  (beatValid),
        .beat       (beat)
    );

    memResultAssemble #(.ADDR_W(ADDR_W)) uAssemble (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .beatValid     (beatValid),
        .beat          (beat),
        .ramRdata      (ramRdata),
        .busyResult    (busyResult),
        .fetchRspValid (fetchRspValid),
        .fetchRsp      (fetchRsp),
        .fetchRspReady (fetchRspReady),
        .dataRspValid  (dataRspValid),
        .dataRsp       (dataRsp),
        .dataRspReady  (dataRspReady)
    );

    byteRam #(.ADDR_W(ADDR_W)) uRam (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

`default_nettype wire

/* hw/memResultAssemble.sv */
`default_nettype none

module memResultAssemble
    import memPkg::*;
#(
    parameter int ADDR_W = 17
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,

    input  logic              beatValid,
    input  memBeatT           beat,
    input  logic [BYTE_W-1:0] ramRdata,

    output logic              busyResult,

    output logic              fetchRspValid,
    output fetchRspT          fetchRsp,
    input  logic              fetchRspReady,

    output logic              dataRspValid,
    output dataRspT           dataRsp,
    input  logic              dataRspReady
);

    memBeatT           beatD;
    logic              beatDValid;
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] merged;
    logic              readDone;
    logic              storeDone;

    // lane 0 starts a fresh zero-extended word
    always_comb begin
        merged = (beatD.idx == 2'd0) ? {DATA_W{1'b0}} : word;
        merged[BYTE_W*beatD.idx +: BYTE_W] = ramRdata;
    end

    assign readDone  = beatDValid && beatD.last && (beatD.op != opStore);
    assign storeDone = beatValid && beat.last && (beat.op == opStore);

    // also covers a read whose result lands next edge
    assign busyResult = fetchRspValid || dataRspValid || (beatDValid && beatD.last);

    always_ff @(posedge clk) begin
        if (rst) begin
            beatDValid    <= 1'b0;
            fetchRspValid <= 1'b0;
            dataRspValid  <= 1'b0;
        end else if (!stall) begin
            beatDValid <= beatValid;
            if (fetchRspValid && fetchRspReady) begin
                fetchRspValid <= 1'b0;
            end
            if (dataRspValid && dataRspReady) begin
                dataRspValid <= 1'b0;
            end
            if (readDone && beatD.op == opFetch) begin
                fetchRspValid <= 1'b1;
            end
            if ((readDone && beatD.op == opLoad) || storeDone) begin
                dataRspValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            beatD <= beat;
            if (beatDValid && beatD.op != opStore) begin
                word <= merged;
            end
            if (readDone && beatD.op == opFetch) begin
                fetchRsp.inst <= merged;
            end
            if (readDone && beatD.op == opLoad) begin
                dataRsp <= '{rdata: merged, isStore: 1'b0};
            end else if (storeDone) begin
                dataRsp <= '{rdata: {DATA_W{1'b0}}, isStore: 1'b1};
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !(fetchRspValid && dataRspValid))
        else $error("fetch and data responses valid together");

endmodule

`default_nettype wire

/* hw/memByteSequencer.sv */
`default_nettype none

module memByteSequencer
    import memPkg::*;
#(
    parameter int ADDR_W = 17
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,

    input  logic              reqValid,
    input  memReqT            req,
    output logic              reqReady,

    input  logic              busyResult,

    output logic [ADDR_W-1:0] ramAddr,
    output logic              ramWe,
    output logic [BYTE_W-1:0] ramWdata,

    output logic              beatValid,
    output memBeatT           beat
);

    typedef enum logic {
        seqIdle,
        seqRun
    } seqStateE;

    seqStateE          state;
    memReqT            cur;
    logic [1:0]        cnt;
    logic [ADDR_W-1:0] curAddr;
    logic [ADDR_W-1:0] lastAddr;
    logic              take;
    logic              lastByte;
    logic              running;

    assign running  = (state == seqRun);
    assign reqReady = (state == seqIdle) && !busyResult;
    assign take     = reqValid && reqReady && !stall;

    assign lastByte = ({1'b0, cnt} == cur.len - 3'd1);
    assign curAddr  = cur.addr[ADDR_W-1:0] + ADDR_W'(cnt);

    // keep re-reading the previous address under stall so that
    // the RAM output register effectively holds its byte
    assign ramAddr = (stall || !running) ? lastAddr : curAddr;

    assign ramWe    = running && (cur.op == opStore) && !stall;
    assign ramWdata = cur.wdata[BYTE_W*cnt +: BYTE_W];

    assign beatValid = running;
    assign beat      = '{op: cur.op, idx: cnt, last: lastByte};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seqIdle;
            cnt   <= 2'd0;
        end else if (!stall) begin
            case (state)
                seqIdle: begin
                    if (take) begin
                        state <= seqRun;
                        cnt   <= 2'd0;
                    end
                end
                seqRun: begin
                    cnt <= cnt + 2'd1;
                    if (lastByte) begin
                        state <= seqIdle;
                    end
                end
                default: begin
                    state <= seqIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (take) begin
                cur <= req;
            end
            lastAddr <= ramAddr;
        end
    end

    // writes stay inside the store's own bytes
    assert property (@(posedge clk) disable iff (rst)
        ramWe |-> ({1'b0, cnt} < cur.len))
        else $error("RAM write past the last byte of a store");

endmodule

`default_nettype wire

/* hw/memRequestDecode.sv */
`default_nettype none

module memRequestDecode
    import memPkg::*;
#(
    parameter int ADDR_W = 17
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,

    input  logic              fetchValid,
    input  logic [ADDR_W-1:0] fetchAddr,
    output logic              fetchReady,

    input  logic              dataValid,
    input  memReqT            dataReq,
    output logic              dataReady,

    output logic              reqValid,
    output memReqT            req,
    input  logic              reqReady
);

    logic   held;
    memReqT heldReq;
    memReqT fetchReq;
    logic   canAccept;
    logic   takeData;
    logic   takeFetch;
    logic   handOff;

    // fetch becomes a plain four byte read
    assign fetchReq.op    = opFetch;
    assign fetchReq.addr  = REQ_ADDR_W'(fetchAddr);
    assign fetchReq.len   = FETCH_LEN;
    assign fetchReq.wdata = {DATA_W{1'b0}};

    // slot frees up when the sequencer takes it this cycle
    assign canAccept = !held || reqReady;

    // data port always wins
    assign dataReady  = canAccept;
    assign fetchReady = canAccept && !dataValid;

    assign takeData  = dataValid && dataReady && !stall;
    assign takeFetch = fetchValid && fetchReady && !stall;
    assign handOff   = held && reqReady && !stall;

    assign reqValid = held;
    assign req      = heldReq;

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (!stall) begin
            if (takeData || takeFetch) begin
                held <= 1'b1;
            end else if (handOff) begin
                held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (takeData) begin
                heldReq <= dataReq;
            end else if (takeFetch) begin
                heldReq <= fetchReq;
            end
        end
    end

    // requester must only send loads and stores of legal length
    assert property (@(posedge clk) disable iff (rst)
        dataValid |-> (dataReq.op != opFetch) && lenOk(dataReq.len))
        else $error("bad data request op %0d len %0d", dataReq.op, dataReq.len);

endmodule

`default_nettype wire

/* hw/byteRam.sv */
`default_nettype none

module byteRam #(
    parameter int ADDR_W = 17
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    input  logic              we,
    input  logic [7:0]        wdata,
    output logic [7:0]        rdata
);

    logic [7:0] mem [2**ADDR_W];

    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = 8'h00;
        end
    end

    // read returns the old byte on a write cycle
    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* hw/memPkg.sv */
`default_nettype none

package memPkg;

    // word width seen by the core
    localparam int DATA_W = 32;

    // address field in requests; modules use the low ADDR_W bits
    localparam int REQ_ADDR_W = 32;

    localparam int BYTE_W = 8;

    // a fetch always reads one full instruction
    localparam logic [2:0] FETCH_LEN = 3'd4;

    typedef enum logic [1:0] {
        opFetch,
        opLoad,
        opStore
    } memOpE;

    typedef struct packed {
        memOpE                 op;
        logic [REQ_ADDR_W-1:0] addr;
        logic [2:0]            len;
        logic [DATA_W-1:0]     wdata;
    } memReqT;

    // one byte access as issued to the RAM
    typedef struct packed {
        memOpE      op;
        logic [1:0] idx;
        logic       last;
    } memBeatT;

    typedef struct packed {
        logic [DATA_W-1:0] inst;
    } fetchRspT;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              isStore;
    } dataRspT;

    // only byte, half and word accesses
    function automatic logic lenOk(input logic [2:0] len);
        return (len == 3'd1) || (len == 3'd2) || (len == 3'd4);
    endfunction

endpackage

`default_nettype wire
